/* build.sh */
#!/bin/sh
# Build and run the JTAG TAP testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=sim_jtag_tap

verilator --binary --timing --assert \
    --top-module tb_jtag_tap --Mdir "$OBJ" -o "$BIN" \
    -f jtag_tap.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* design/jtag_config.svh */
`ifndef JTAG_CONFIG_SVH
`define JTAG_CONFIG_SVH

// Instruction register geometry
`define JTAG_IR_LENGTH 5
// Device identity, bit 0 must be 1
`define JTAG_IDCODE_VALUE 32'h2B7E_104D
`define JTAG_USER_WIDTH 16

// Instruction codes, anything else selects BYPASS
`define JTAG_INSTR_IDCODE 5'd1
`define JTAG_INSTR_USER 5'd2
// Loaded in Capture-IR, low bits fixed at 01
`define JTAG_IR_CAPTURE 5'b00101

`endif

/* design/jtag_instr_decode.sv */
`timescale 1ns/1ps
`include "jtag_config.svh"

module jtag_instr_decode (
    input  jtag_pkg::ir_t ir_i,
    input  logic          capture_dr_i,
    input  logic          shift_dr_i,
    input  logic          update_dr_i,
    output logic          idcode_capture_o,
    output logic          idcode_shift_o,
    output logic          user_capture_o,
    output logic          user_shift_o,
    output logic          user_update_o,
    output logic          bypass_capture_o,
    output logic          bypass_shift_o,
    output logic [1:0]    dr_sel_o
);

    import jtag_pkg::*;

    logic idcode_sel;
    logic user_sel;
    logic bypass_sel;

    // Code to register map, BYPASS for everything unknown
    always_comb begin
        idcode_sel = 1'b0;
        user_sel   = 1'b0;
        dr_sel_o   = DR_SEL_BYPASS;
        case (ir_i)
            `JTAG_INSTR_IDCODE: begin
                idcode_sel = 1'b1;
                dr_sel_o   = DR_SEL_IDCODE;
            end
            `JTAG_INSTR_USER: begin
                user_sel = 1'b1;
                dr_sel_o = DR_SEL_USER;
            end
            default: ;
        endcase
    end

    assign bypass_sel = ~(idcode_sel | user_sel);

    // Gate the DR strobes per register
    assign idcode_capture_o = capture_dr_i & idcode_sel;
    assign idcode_shift_o   = shift_dr_i & idcode_sel;
    assign user_capture_o   = capture_dr_i & user_sel;
    assign user_shift_o     = shift_dr_i & user_sel;
    assign user_update_o    = update_dr_i & user_sel;
    assign bypass_capture_o = capture_dr_i & bypass_sel;
    assign bypass_shift_o   = shift_dr_i & bypass_sel;

endmodule

/* design/jtag_pkg.sv */
`include "jtag_config.svh"

package jtag_pkg;

    // Standard TAP controller states
    typedef enum logic [3:0] {
        TEST_LOGIC_RESET = 4'd0,
        RUN_TEST_IDLE    = 4'd1,
        SELECT_DR_SCAN   = 4'd2,
        CAPTURE_DR       = 4'd3,
        SHIFT_DR         = 4'd4,
        EXIT1_DR         = 4'd5,
        PAUSE_DR         = 4'd6,
        EXIT2_DR         = 4'd7,
        UPDATE_DR        = 4'd8,
        SELECT_IR_SCAN   = 4'd9,
        CAPTURE_IR       = 4'd10,
        SHIFT_IR         = 4'd11,
        EXIT1_IR         = 4'd12,
        PAUSE_IR         = 4'd13,
        EXIT2_IR         = 4'd14,
        UPDATE_IR        = 4'd15
    } tap_state_e;

    // Scan register payloads
    typedef logic [`JTAG_IR_LENGTH-1:0]  ir_t;
    typedef logic [31:0]                 idcode_t;
    typedef logic [`JTAG_USER_WIDTH-1:0] user_word_t;

    // TDO source select encoding
    localparam logic [1:0] DR_SEL_BYPASS = 2'd0;
    localparam logic [1:0] DR_SEL_IDCODE = 2'd1;
    localparam logic [1:0] DR_SEL_USER   = 2'd2;

endpackage

/* design/jtag_scan_reg.sv */
`timescale 1ns/1ps

module jtag_scan_reg #(
    parameter type payload_t  = logic [7:0],
    parameter bit  HAS_UPDATE = 1'b1
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     clear_i,
    input  logic     shift_en_i,
    input  logic     capture_en_i,
    input  logic     update_en_i,
    input  logic     serial_i,
    input  payload_t capture_val_i,
    input  payload_t reset_val_i,
    output logic     serial_o,
    output payload_t parallel_o,
    output logic     updated_o
);

    // Shift stage, serial bit enters at the top
    payload_t shift_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shift_q <= '0;
        end else if (capture_en_i) begin
            shift_q <= capture_val_i;
        end else if (shift_en_i) begin
            // One step toward bit 0, also fine for a single bit
            shift_q <= payload_t'({serial_i, shift_q} >> 1);
        end
    end

    assign serial_o = shift_q[0];

    // ------------------------------
    // Held stage
    // ------------------------------
    if (HAS_UPDATE) begin : g_update
        payload_t held_q;
        logic     updated_q;

        always_ff @(posedge clk) begin
            if (!rst_n || clear_i) begin
                held_q <= reset_val_i;
            end else if (update_en_i) begin
                held_q <= shift_q;
            end
        end

        // Strobe lines up with the new held value
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                updated_q <= 1'b0;
            end else begin
                updated_q <= update_en_i;
            end
        end

        assign parallel_o = held_q;
        assign updated_o  = updated_q;
    end else begin : g_no_update
        // Capture-only register, shift stage is visible directly
        assign parallel_o = shift_q;
        assign updated_o  = 1'b0;
    end

endmodule

/* design/jtag_tap_fsm.sv */
`timescale 1ns/1ps

module jtag_tap_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 tck_rise_i,
    input  logic                 tck_fall_i,
    input  logic                 tms_i,
    output logic                 capture_ir_o,
    output logic                 shift_ir_o,
    output logic                 update_ir_o,
    output logic                 capture_dr_o,
    output logic                 shift_dr_o,
    output logic                 update_dr_o,
    output logic                 tap_reset_o,
    output jtag_pkg::tap_state_e state_o
);

    import jtag_pkg::*;

    tap_state_e state_q;
    tap_state_e state_d;

    // ------------------------------
    // TMS transition table
    // ------------------------------
    always_comb begin
        case (state_q)
            TEST_LOGIC_RESET: state_d = tms_i ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    state_d = tms_i ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            // DR column
            SELECT_DR_SCAN:   state_d = tms_i ? SELECT_IR_SCAN   : CAPTURE_DR;
            CAPTURE_DR:       state_d = tms_i ? EXIT1_DR         : SHIFT_DR;
            SHIFT_DR:         state_d = tms_i ? EXIT1_DR         : SHIFT_DR;
            EXIT1_DR:         state_d = tms_i ? UPDATE_DR        : PAUSE_DR;
            PAUSE_DR:         state_d = tms_i ? EXIT2_DR         : PAUSE_DR;
            EXIT2_DR:         state_d = tms_i ? UPDATE_DR        : SHIFT_DR;
            UPDATE_DR:        state_d = tms_i ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            // IR column
            SELECT_IR_SCAN:   state_d = tms_i ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       state_d = tms_i ? EXIT1_IR         : SHIFT_IR;
            SHIFT_IR:         state_d = tms_i ? EXIT1_IR         : SHIFT_IR;
            EXIT1_IR:         state_d = tms_i ? UPDATE_IR        : PAUSE_IR;
            PAUSE_IR:         state_d = tms_i ? EXIT2_IR         : PAUSE_IR;
            EXIT2_IR:         state_d = tms_i ? UPDATE_IR        : SHIFT_IR;
            UPDATE_IR:        state_d = tms_i ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            default:          state_d = TEST_LOGIC_RESET;
        endcase
    end

    // State only moves on a TCK rise
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= TEST_LOGIC_RESET;
        end else if (tck_rise_i) begin
            state_q <= state_d;
        end
    end

    // ------------------------------
    // Strobes
    // ------------------------------
    // Rise strobes act in the state they are named after
    assign capture_ir_o = tck_rise_i && (state_q == CAPTURE_IR);
    assign shift_ir_o   = tck_rise_i && (state_q == SHIFT_IR);
    assign capture_dr_o = tck_rise_i && (state_q == CAPTURE_DR);
    assign shift_dr_o   = tck_rise_i && (state_q == SHIFT_DR);
    assign update_dr_o  = tck_rise_i && (state_q == UPDATE_DR);
    assign tap_reset_o  = tck_rise_i && (state_q == TEST_LOGIC_RESET);

    // New instruction latched mid-state, on the falling edge
    assign update_ir_o  = tck_fall_i && (state_q == UPDATE_IR);

    assign state_o = state_q;

endmodule

/* design/jtag_tap_top.sv */
`timescale 1ns/1ps
`include "jtag_config.svh"

module jtag_tap_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 tck_i,
    input  logic                 tms_i,
    input  logic                 tdi_i,
    output logic                 tdo_o,
    output logic                 tdo_oe_o,
    output jtag_pkg::ir_t        ir_o,
    input  jtag_pkg::user_word_t user_status_i,
    output jtag_pkg::user_word_t user_data_o,
    output logic                 user_update_o
);

    import jtag_pkg::*;

    // Sampled pads and edges
    logic tck_rise, tck_fall, tms_s, tdi_s;
    // Controller strobes
    logic capture_ir, shift_ir, update_ir;
    logic capture_dr, shift_dr, update_dr, tap_reset;
    tap_state_e tap_state;
    logic in_shift_ir;
    // Per-register enables
    logic idcode_capture, idcode_shift;
    logic user_capture, user_shift, user_update;
    logic bypass_capture, bypass_shift;
    logic [1:0] dr_sel;
    // Serial outputs
    logic ir_bit, bypass_bit, idcode_bit, user_bit;

    jtag_tck_sampler u_sampler (
        .clk(clk), .rst_n(rst_n),
        .tck_i(tck_i), .tms_i(tms_i), .tdi_i(tdi_i),
        .tck_rise_o(tck_rise), .tck_fall_o(tck_fall),
        .tms_o(tms_s), .tdi_o(tdi_s)
    );

    jtag_tap_fsm u_fsm (
        .clk(clk), .rst_n(rst_n),
        .tck_rise_i(tck_rise), .tck_fall_i(tck_fall), .tms_i(tms_s),
        .capture_ir_o(capture_ir), .shift_ir_o(shift_ir), .update_ir_o(update_ir),
        .capture_dr_o(capture_dr), .shift_dr_o(shift_dr), .update_dr_o(update_dr),
        .tap_reset_o(tap_reset), .state_o(tap_state)
    );

    // Level for the TDO mux, strobes only last one clk
    assign in_shift_ir = (tap_state == SHIFT_IR);

    jtag_instr_decode u_decode (
        .ir_i(ir_o),
        .capture_dr_i(capture_dr), .shift_dr_i(shift_dr), .update_dr_i(update_dr),
        .idcode_capture_o(idcode_capture), .idcode_shift_o(idcode_shift),
        .user_capture_o(user_capture), .user_shift_o(user_shift),
        .user_update_o(user_update),
        .bypass_capture_o(bypass_capture), .bypass_shift_o(bypass_shift),
        .dr_sel_o(dr_sel)
    );

    // ------------------------------
    // Scan registers
    // ------------------------------
    // Instruction register, back to IDCODE in Test-Logic-Reset
    jtag_scan_reg #(.payload_t(ir_t), .HAS_UPDATE(1'b1)) u_ir_reg (
        .clk(clk), .rst_n(rst_n), .clear_i(tap_reset),
        .shift_en_i(shift_ir), .capture_en_i(capture_ir), .update_en_i(update_ir),
        .serial_i(tdi_s), .capture_val_i(`JTAG_IR_CAPTURE),
        .reset_val_i(`JTAG_INSTR_IDCODE),
        .serial_o(ir_bit), .parallel_o(ir_o), .updated_o()
    );

    // Single-bit BYPASS, captures 0
    jtag_scan_reg #(.payload_t(logic [0:0]), .HAS_UPDATE(1'b0)) u_bypass_reg (
        .clk(clk), .rst_n(rst_n), .clear_i(1'b0),
        .shift_en_i(bypass_shift), .capture_en_i(bypass_capture), .update_en_i(1'b0),
        .serial_i(tdi_s), .capture_val_i(1'b0), .reset_val_i(1'b0),
        .serial_o(bypass_bit), .parallel_o(), .updated_o()
    );

    jtag_scan_reg #(.payload_t(idcode_t), .HAS_UPDATE(1'b0)) u_idcode_reg (
        .clk(clk), .rst_n(rst_n), .clear_i(1'b0),
        .shift_en_i(idcode_shift), .capture_en_i(idcode_capture), .update_en_i(1'b0),
        .serial_i(tdi_s), .capture_val_i(`JTAG_IDCODE_VALUE), .reset_val_i('0),
        .serial_o(idcode_bit), .parallel_o(), .updated_o()
    );

    // USER captures system status, delivers on Update-DR
    jtag_scan_reg #(.payload_t(user_word_t), .HAS_UPDATE(1'b1)) u_user_reg (
        .clk(clk), .rst_n(rst_n), .clear_i(1'b0),
        .shift_en_i(user_shift), .capture_en_i(user_capture), .update_en_i(user_update),
        .serial_i(tdi_s), .capture_val_i(user_status_i), .reset_val_i('0),
        .serial_o(user_bit), .parallel_o(user_data_o), .updated_o(user_update_o)
    );

    jtag_tdo_driver u_tdo (
        .clk(clk), .rst_n(rst_n),
        .tck_fall_i(tck_fall), .shift_ir_i(in_shift_ir),
        .ir_bit_i(ir_bit), .bypass_bit_i(bypass_bit),
        .idcode_bit_i(idcode_bit), .user_bit_i(user_bit),
        .dr_sel_i(dr_sel),
        .tdo_o(tdo_o), .tdo_oe_o(tdo_oe_o)
    );

endmodule

/* design/jtag_tck_sampler.sv */
`timescale 1ns/1ps

module jtag_tck_sampler (
    input  logic clk,
    input  logic rst_n,
    input  logic tck_i,
    input  logic tms_i,
    input  logic tdi_i,
    output logic tck_rise_o,
    output logic tck_fall_o,
    output logic tms_o,
    output logic tdi_o
);

    // Two-flop synchronizers, bit 1 is the settled sample
    logic [1:0] tck_sync;
    logic [1:0] tms_sync;
    logic [1:0] tdi_sync;
    // Last settled TCK level
    logic       tck_prev;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tck_sync <= 2'b00;
            tms_sync <= 2'b00;
            tdi_sync <= 2'b00;
            tck_prev <= 1'b0;
        end else begin
            tck_sync <= {tck_sync[0], tck_i};
            tms_sync <= {tms_sync[0], tms_i};
            tdi_sync <= {tdi_sync[0], tdi_i};
            tck_prev <= tck_sync[1];
        end
    end

    // Edge pulses, one clk wide
    assign tck_rise_o = tck_sync[1] & ~tck_prev;
    assign tck_fall_o = ~tck_sync[1] & tck_prev;

    // TMS and TDI aligned with the TCK sample
    assign tms_o = tms_sync[1];
    assign tdi_o = tdi_sync[1];

endmodule

/* design/jtag_tdo_driver.sv */
`timescale 1ns/1ps

module jtag_tdo_driver (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tck_fall_i,
    input  logic       shift_ir_i,
    input  logic       ir_bit_i,
    input  logic       bypass_bit_i,
    input  logic       idcode_bit_i,
    input  logic       user_bit_i,
    input  logic [1:0] dr_sel_i,
    output logic       tdo_o,
    output logic       tdo_oe_o
);

    import jtag_pkg::*;

    logic dr_bit;
    logic tdo_bit;

    // Data register source
    always_comb begin
        case (dr_sel_i)
            DR_SEL_IDCODE: dr_bit = idcode_bit_i;
            DR_SEL_USER:   dr_bit = user_bit_i;
            default:       dr_bit = bypass_bit_i;
        endcase
    end

    // IR wins while the controller sits in Shift-IR
    assign tdo_bit = shift_ir_i ? ir_bit_i : dr_bit;

    // Launch on the falling edge, stable for the next rise
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tdo_o    <= 1'b0;
            tdo_oe_o <= 1'b0;
        end else if (tck_fall_i) begin
            tdo_o    <= tdo_bit;
            tdo_oe_o <= 1'b1;
        end
    end

endmodule

/* dv/jtag_tap_properties.sv */
`timescale 1ns/1ps

module jtag_tap_properties (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 tck_rise_i,
    input logic                 tms_i,
    input logic                 capture_ir_i,
    input logic                 shift_ir_i,
    input logic                 update_ir_i,
    input logic                 capture_dr_i,
    input logic                 shift_dr_i,
    input logic                 update_dr_i,
    input logic                 tap_reset_i,
    input jtag_pkg::tap_state_e state_i
);

    import jtag_pkg::*;

    // All scan strobes side by side
    logic [5:0] scan_strobes;
    // Run of TCK rises with TMS high, saturates at five
    logic [2:0] tms_high_rises;

    assign scan_strobes = {capture_ir_i, shift_ir_i, update_ir_i,
                           capture_dr_i, shift_dr_i, update_dr_i};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tms_high_rises <= 3'd0;
        end else if (tck_rise_i) begin
            if (!tms_i) begin
                tms_high_rises <= 3'd0;
            end else if (tms_high_rises < 3'd5) begin
                tms_high_rises <= tms_high_rises + 3'd1;
            end
        end
    end

    // ------------------------------
    // Strobe checks
    // ------------------------------
    strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(scan_strobes))
        else $error("More than one IR or DR strobe in the same cycle");

    // Update-IR acts mid-state on the fall so the state has not moved yet
    update_ir_on_fall: assert property (@(posedge clk) disable iff (!rst_n)
        update_ir_i |=> (state_i == UPDATE_IR))
        else $error("Update-IR strobe not on a TCK fall inside Update-IR");

    // Update-DR acts on the rise that leaves Update-DR
    update_dr_on_rise: assert property (@(posedge clk) disable iff (!rst_n)
        update_dr_i |=> (state_i != UPDATE_DR))
        else $error("Update-DR strobe not on the TCK rise that leaves Update-DR");

    // ------------------------------
    // Test-Logic-Reset
    // ------------------------------
    // Five TMS-high rises reach Test-Logic-Reset from any state
    reset_after_five_tms: assert property (@(posedge clk) disable iff (!rst_n)
        (tck_rise_i && tms_high_rises == 3'd5) |-> tap_reset_i)
        else $error("TCK rise after five TMS-high rises without the TAP reset strobe");

endmodule

/* dv/tb_jtag_tap.sv */
`timescale 1ns/1ps
`include "jtag_config.svh"

module tb_jtag_tap;

    import jtag_pkg::*;

    localparam int CLK_PERIOD = 4;
    // clk cycles per TCK half period
    localparam int HALF_TCK   = 4;
    localparam int N_BYPASS   = 4;
    localparam int N_USER     = 8;
    // TCK cycles for reset and IDCODE 38, IR 11, bypass 32 each, user 11 + 21 each
    // and pause and reset 87
    localparam int PLANNED_TCK = 38 + 11 + N_BYPASS * 32 + 11 + N_USER * 21 + 87;
    localparam int TIMEOUT_NS  = PLANNED_TCK * 2 * HALF_TCK * CLK_PERIOD + 1000;

    logic       clk;
    logic       rst_n;
    logic       tck;
    logic       tms;
    logic       tdi;
    logic       tdo;
    logic       tdo_oe;
    ir_t        ir;
    user_word_t user_status;
    user_word_t user_data;
    logic       user_update;

    // Reference model
    tap_state_e m_state;
    ir_t        m_ir;
    ir_t        m_ir_shift;
    user_word_t m_user;
    user_word_t m_user_shift;
    int         m_updates;

    // Update pulse monitor
    int         seen_updates;
    user_word_t pulse_data;

    logic [31:0] lfsr;
    int          errors;
    int          checks;

    jtag_tap_top dut (
        .clk(clk),
        .rst_n(rst_n),
        .tck_i(tck),
        .tms_i(tms),
        .tdi_i(tdi),
        .tdo_o(tdo),
        .tdo_oe_o(tdo_oe),
        .ir_o(ir),
        .user_status_i(user_status),
        .user_data_o(user_data),
        .user_update_o(user_update)
    );

    bind jtag_tap_fsm jtag_tap_properties u_props (
        .clk(clk), .rst_n(rst_n),
        .tck_rise_i(tck_rise_i), .tms_i(tms_i),
        .capture_ir_i(capture_ir_o), .shift_ir_i(shift_ir_o), .update_ir_i(update_ir_o),
        .capture_dr_i(capture_dr_o), .shift_dr_i(shift_dr_o), .update_dr_i(update_dr_o),
        .tap_reset_i(tap_reset_o), .state_i(state_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Counts user pulses and keeps the word seen with each
    always @(posedge clk) begin
        if (!rst_n) begin
            seen_updates <= 0;
            pulse_data   <= '0;
        end else if (user_update) begin
            seen_updates <= seen_updates + 1;
            pulse_data   <= user_data;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Error: watchdog expired, the TAP tests did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

    // ------------------------------
    // Random bits and compares
    // ------------------------------
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic check_ir(input string name, input ir_t exp, input ir_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_idcode(input string name, input idcode_t exp, input idcode_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_user(input string name, input user_word_t exp,
                              input user_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // ------------------------------
    // TAP model and pad driving
    // ------------------------------
    // Standard IEEE 1149.1 state diagram
    function automatic tap_state_e next_state(input tap_state_e s, input logic t);
        case (s)
            TEST_LOGIC_RESET: return t ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    return t ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_DR_SCAN:   return t ? SELECT_IR_SCAN : CAPTURE_DR;
            CAPTURE_DR:       return t ? EXIT1_DR : SHIFT_DR;
            SHIFT_DR:         return t ? EXIT1_DR : SHIFT_DR;
            EXIT1_DR:         return t ? UPDATE_DR : PAUSE_DR;
            PAUSE_DR:         return t ? EXIT2_DR : PAUSE_DR;
            EXIT2_DR:         return t ? UPDATE_DR : SHIFT_DR;
            UPDATE_DR:        return t ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_IR_SCAN:   return t ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       return t ? EXIT1_IR : SHIFT_IR;
            SHIFT_IR:         return t ? EXIT1_IR : SHIFT_IR;
            EXIT1_IR:         return t ? UPDATE_IR : PAUSE_IR;
            PAUSE_IR:         return t ? EXIT2_IR : PAUSE_IR;
            EXIT2_IR:         return t ? UPDATE_IR : SHIFT_IR;
            default:          return t ? SELECT_DR_SCAN : RUN_TEST_IDLE;
        endcase
    endfunction

    // One TCK period with TDO taken just before the rise
    task automatic tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
        tck = 1'b0;
        tms = tms_v;
        tdi = tdi_v;
        // New instruction takes effect on the fall in Update-IR
        if (m_state == UPDATE_IR) m_ir = m_ir_shift;
        repeat (HALF_TCK) @(negedge clk);
        tdo_v = tdo;
        tck   = 1'b1;
        case (m_state)
            TEST_LOGIC_RESET: m_ir = `JTAG_INSTR_IDCODE;
            CAPTURE_IR:       m_ir_shift = `JTAG_IR_CAPTURE;
            SHIFT_IR:         m_ir_shift = {tdi_v, m_ir_shift[`JTAG_IR_LENGTH-1:1]};
            CAPTURE_DR: begin
                if (m_ir == `JTAG_INSTR_USER) m_user_shift = user_status;
            end
            SHIFT_DR: begin
                if (m_ir == `JTAG_INSTR_USER) begin
                    m_user_shift = {tdi_v, m_user_shift[`JTAG_USER_WIDTH-1:1]};
                end
            end
            UPDATE_DR: begin
                if (m_ir == `JTAG_INSTR_USER) begin
                    m_user = m_user_shift;
                    m_updates++;
                end
            end
            default: ;
        endcase
        m_state = next_state(m_state, tms_v);
        repeat (HALF_TCK) @(negedge clk);
    endtask

    // Scan from Run-Test/Idle and back to it with the LSB first
    // pause_at picks the bit after which the scan detours through Pause
    task automatic scan(input logic is_ir, input int n, input logic [31:0] din,
                        input int pause_at, output logic [31:0] dout);
        logic bit_out;
        logic last;
        dout = '0;
        tck_cycle(1'b1, 1'b0, bit_out);
        if (is_ir) tck_cycle(1'b1, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
        for (int i = 0; i < n; i++) begin
            last = (i == n - 1) || (i == pause_at);
            tck_cycle(last, din[i], bit_out);
            dout[i] = bit_out;
            if (i == pause_at) begin
                // Exit1, Pause twice, Exit2, back to Shift
                tck_cycle(1'b0, 1'b0, bit_out);
                tck_cycle(1'b0, 1'b0, bit_out);
                tck_cycle(1'b1, 1'b0, bit_out);
                tck_cycle(1'b0, 1'b0, bit_out);
            end
        end
        // Exit1 to Update, then Run-Test/Idle
        tck_cycle(1'b1, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        logic [31:0] dout;
        logic [31:0] rnd;
        logic        dummy;
        ir_t         code;
        user_word_t  word;
        user_word_t  status;
        errors       = 0;
        checks       = 0;
        lfsr         = 32'h1b4b;
        m_state      = TEST_LOGIC_RESET;
        m_ir         = `JTAG_INSTR_IDCODE;
        m_ir_shift   = '0;
        m_user       = '0;
        m_user_shift = '0;
        m_updates    = 0;
        rst_n        = 1'b0;
        tck          = 1'b0;
        tms          = 1'b1;
        tdi          = 1'b0;
        user_status  = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Reset defaults and IDCODE without an IR scan
        check_ir("reset ir", `JTAG_INSTR_IDCODE, ir);
        check_bit("reset tdo_oe", 1'b0, tdo_oe);
        check_bit("reset tdo", 1'b0, tdo);
        check_bit("reset user_update", 1'b0, user_update);
        check_user("reset user_data", '0, user_data);
        tck_cycle(1'b0, 1'b0, dummy);
        rand_bits(32, rnd);
        scan(1'b0, 32, rnd, -1, dout);
        check_idcode("idcode after reset", `JTAG_IDCODE_VALUE, dout);
        check_bit("tdo_oe after first fall", 1'b1, tdo_oe);

        // IR capture pattern and update
        rand_bits(`JTAG_IR_LENGTH, rnd);
        code = ir_t'(rnd);
        scan(1'b1, `JTAG_IR_LENGTH, 32'(code), -1, dout);
        check_ir("ir capture", `JTAG_IR_CAPTURE, ir_t'(dout));
        check_ir("ir update", code, ir);

        // BYPASS with all zeros, all ones and random codes
        for (int k = 0; k < N_BYPASS; k++) begin
            if (k == 0) begin
                code = '0;
            end else if (k == 1) begin
                code = '1;
            end else begin
                do begin
                    rand_bits(`JTAG_IR_LENGTH, rnd);
                    code = ir_t'(rnd);
                end while (code == `JTAG_INSTR_IDCODE || code == `JTAG_INSTR_USER);
            end
            scan(1'b1, `JTAG_IR_LENGTH, 32'(code), -1, dout);
            check_ir("bypass ir", code, ir);
            rand_bits(16, rnd);
            scan(1'b0, 16, rnd, -1, dout);
            // One bit of delay behind a captured 0
            for (int i = 0; i < 16; i++) begin
                check_bit($sformatf("bypass bit %0d", i), (i == 0) ? 1'b0 : rnd[i-1],
                          dout[i]);
            end
        end

        // USER scans of random words
        scan(1'b1, `JTAG_IR_LENGTH, 32'(`JTAG_INSTR_USER), -1, dout);
        check_ir("user ir", `JTAG_INSTR_USER, ir);
        for (int k = 0; k < N_USER; k++) begin
            rand_bits(`JTAG_USER_WIDTH, rnd);
            status      = user_word_t'(rnd);
            user_status = status;
            rand_bits(`JTAG_USER_WIDTH, rnd);
            word = user_word_t'(rnd);
            scan(1'b0, `JTAG_USER_WIDTH, 32'(word), -1, dout);
            check_user("user capture", status, user_word_t'(dout));
            check_user("user data", word, user_data);
            check_user("user data at pulse", m_user, pulse_data);
            check_count("user pulses", m_updates, seen_updates);
        end

        // Same scans routed through Pause-IR and Pause-DR
        scan(1'b1, `JTAG_IR_LENGTH, 32'(`JTAG_INSTR_USER), 2, dout);
        check_ir("paused ir capture", `JTAG_IR_CAPTURE, ir_t'(dout));
        check_ir("paused ir update", `JTAG_INSTR_USER, ir);
        rand_bits(`JTAG_USER_WIDTH, rnd);
        status      = user_word_t'(rnd);
        user_status = status;
        rand_bits(`JTAG_USER_WIDTH, rnd);
        word = user_word_t'(rnd);
        scan(1'b0, `JTAG_USER_WIDTH, 32'(word), 7, dout);
        check_user("paused user capture", status, user_word_t'(dout));
        check_user("paused user data", word, user_data);
        check_count("paused user pulses", m_updates, seen_updates);

        // Five TMS-high cycles bring back IDCODE
        repeat (5) tck_cycle(1'b1, 1'b0, dummy);
        check_ir("ir after tms reset", m_ir, ir);
        check_ir("idcode after tms reset", `JTAG_INSTR_IDCODE, ir);
        tck_cycle(1'b0, 1'b0, dummy);
        rand_bits(32, rnd);
        scan(1'b0, 32, rnd, 13, dout);
        check_idcode("paused idcode", `JTAG_IDCODE_VALUE, dout);
        check_count("total user pulses", m_updates, seen_updates);
        check_user("user data kept", m_user, user_data);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* jtag_tap.f */
+incdir+design
design/jtag_pkg.sv
design/jtag_tck_sampler.sv
design/jtag_tap_fsm.sv
design/jtag_instr_decode.sv
design/jtag_scan_reg.sv
design/jtag_tdo_driver.sv
design/jtag_tap_top.sv
dv/jtag_tap_properties.sv
dv/tb_jtag_tap.sv
